//--- rtl/i2s_pkg.sv
`default_nettype none

package i2s_pkg;

    ////////////////////
    // channel word and frame sizes
    ////////////////////

    localparam int sample_width = 16;  // bits per left or right word

    // roughly (100 MHz / 1.536 MHz) / 2, one half period of sck
    localparam int half_sck_cycles = 33;

    localparam int sck_cnt_width = $clog2(half_sck_cycles);  // divider counts 0 .. 32
    localparam int bit_cnt_width = $clog2(sample_width);     // bit index 15 .. 0

    ////////////////////
    // stereo payload
    ////////////////////

    // left word sits in the upper half so the frame shifts out left first
    typedef struct packed {
        logic [sample_width-1:0] left;   // sent first
        logic [sample_width-1:0] right;  // sent second
    } stereo_sample_t;

endpackage

`default_nettype wire

//--- rtl/i2s_bus_if.sv
`timescale 1ns/1ns
`default_nettype none

// transmit side of the three-wire bus plus the edge strobes
interface i2s_bus_if;

    logic sck;       // serial bit clock, registered in the clk domain
    logic sck_rise;  // one clk wide, same edge sck goes high
    logic sck_fall;  // one clk wide, same edge sck goes low
    logic ws;        // word select, 1 = right channel
    logic sd;        // serial data, msb first

    // bit clock generator side
    modport clock_src (
        output sck,
        output sck_rise,
        output sck_fall
    );

    // serializer side, only needs the edge strobes
    modport shifter (
        input  sck_rise,
        input  sck_fall,
        output ws,
        output sd
    );

endinterface

`default_nettype wire

//--- rtl/i2s_sck_gen.sv
`timescale 1ns/1ns
`default_nettype none

module i2s_sck_gen
    import i2s_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    i2s_bus_if.clock_src bus
);

    logic [sck_cnt_width-1:0] div_cnt;  // clk cycles within the current half period
    logic                     sck_q;
    logic                     rise_q;
    logic                     fall_q;
    logic                     half_done;  // last clk of a half period

    assign half_done = (div_cnt == sck_cnt_width'(half_sck_cycles - 1));

    ////////////////////
    // divider
    ////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            div_cnt <= '0;  // held at 0 through reset
            sck_q   <= 1'b0;
            rise_q  <= 1'b0;
            fall_q  <= 1'b0;
        end
        else
        begin
            if (half_done)
            begin
                div_cnt <= '0;     // wrap
                sck_q   <= ~sck_q; // toggle bit clock
            end
            else
                div_cnt <= div_cnt + 1'b1;

            // strobes line up with the toggle itself
            rise_q <= half_done & ~sck_q;  // low -> high
            fall_q <= half_done & sck_q;   // high -> low
        end
    end

    assign bus.sck      = sck_q;
    assign bus.sck_rise = rise_q;
    assign bus.sck_fall = fall_q;

endmodule

`default_nettype wire

//--- rtl/i2s_serializer.sv
`timescale 1ns/1ns
`default_nettype none

module i2s_serializer
    import i2s_pkg::*;
(
    input  logic           clk,
    input  logic           rst_n,
    input  logic           load,       // copy frame_in into the holding register
    input  stereo_sample_t frame_in,
    output logic           frame_req,  // one clk, at the fall that starts a frame
    i2s_bus_if.shifter     bus
);

    localparam int frame_width = $bits(stereo_sample_t);  // 32

    stereo_sample_t           hold_q;   // next frame to send
    logic [frame_width-1:0]   shift_q;  // bits still to go after sd_q
    logic [bit_cnt_width-1:0] bit_idx;  // index of the bit now on sd
    logic                     chan_right; // 1 while the right word is out
    logic                     ws_q;
    logic                     sd_q;

    logic                     word_end;   // lsb of a word on the wire
    logic                     frame_end;  // lsb of the right word on the wire
    logic [bit_cnt_width-1:0] next_idx;
    logic                     next_right;
    logic                     next_ws;

    ////////////////////
    // bit position decode
    ////////////////////

    assign word_end  = (bit_idx == '0);
    assign frame_end = word_end & chan_right;

    assign next_idx   = word_end ? bit_cnt_width'(sample_width - 1) : bit_idx - 1'b1;
    assign next_right = word_end ? ~chan_right : chan_right;

    // ws leads each word by one bit
    // high for right bits 15..1 and for the left lsb
    assign next_ws = next_right ? (next_idx != '0) : (next_idx == '0);

    assign frame_req = bus.sck_fall & frame_end;  // holding reg moves on this cycle

    ////////////////////
    // holding register
    ////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            hold_q <= '0;  // first frame after reset is zero unless loaded
        else if (load)
            hold_q <= frame_in;  // later load in the same frame wins
    end

    ////////////////////
    // shifter
    ////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            shift_q    <= '0;
            bit_idx    <= '0;
            chan_right <= 1'b1;  // parked on the right lsb, so the first fall starts a frame
            ws_q       <= 1'b0;
            sd_q       <= 1'b0;
        end
        else if (bus.sck_fall)  // everything on the wire moves on the falling edge
        begin
            if (frame_end)
            begin
                // take the held frame, its msb goes straight out
                sd_q    <= hold_q[frame_width-1];
                shift_q <= {hold_q[frame_width-2:0], 1'b0};
            end
            else
            begin
                sd_q    <= shift_q[frame_width-1];
                shift_q <= {shift_q[frame_width-2:0], 1'b0};
            end

            bit_idx    <= next_idx;
            chan_right <= next_right;
            ws_q       <= next_ws;
        end
    end

    // pins, registered
    assign bus.ws = ws_q;
    assign bus.sd = sd_q;

endmodule

`default_nettype wire

//--- rtl/i2s_deserializer.sv
`timescale 1ns/1ns
`default_nettype none

module i2s_deserializer
    import i2s_pkg::*;
(
    input  logic           clk,
    input  logic           rst_n,
    input  logic           sck,        // async bus pins
    input  logic           ws,
    input  logic           sd,
    output logic           valid,      // one clk per received frame
    output stereo_sample_t frame_out
);

    localparam int frame_width = $bits(stereo_sample_t);

    logic [2:0]             sync1_q;  // {sck, ws, sd}, first stage
    logic [2:0]             sync2_q;  // second stage
    logic                   sck_s;
    logic                   ws_s;
    logic                   sd_s;
    logic                   sck_prev_q;  // for edge detect

    logic                   bit_rise;   // rising edge of the bus clock
    logic                   ws_d_q;     // ws as sampled one bit earlier
    logic [frame_width-1:0] shift_q;
    logic [frame_width-1:0] shift_next;
    logic                   frame_done; // right lsb being taken in
    logic                   armed_q;    // first boundary seen

    ////////////////////
    // synchronizer
    ////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            sync1_q    <= '0;
            sync2_q    <= '0;
            sck_prev_q <= 1'b0;
        end
        else
        begin
            sync1_q    <= {sck, ws, sd};
            sync2_q    <= sync1_q;
            sck_prev_q <= sck_s;
        end
    end

    assign sck_s = sync2_q[2];
    assign ws_s  = sync2_q[1];
    assign sd_s  = sync2_q[0];

    assign bit_rise   = sck_s & ~sck_prev_q;
    assign shift_next = {shift_q[frame_width-2:0], sd_s};  // msb first in

    // delayed ws still high, new ws low -> this bit is the right lsb
    assign frame_done = bit_rise & ws_d_q & ~ws_s;

    ////////////////////
    // shift in, frame out
    ////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            shift_q   <= '0;
            ws_d_q    <= 1'b0;
            armed_q   <= 1'b0;
            valid     <= 1'b0;
            frame_out <= '0;
        end
        else
        begin
            if (bit_rise)
            begin
                shift_q <= shift_next;
                ws_d_q  <= ws_s;  // one bit behind
            end

            if (frame_done)
                armed_q <= 1'b1;  // first frame may be partial, only arms

            valid <= frame_done & armed_q;
            if (frame_done && armed_q)
                frame_out <= stereo_sample_t'(shift_next);  // left in upper half
        end
    end

endmodule

`default_nettype wire

//--- rtl/i2s_link_top.sv
`timescale 1ns/1ns
`default_nettype none

module i2s_link_top
    import i2s_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,

    // transmit side
    input  logic                    tx_load,
    input  logic [sample_width-1:0] tx_left,
    input  logic [sample_width-1:0] tx_right,
    output logic                    tx_frame_req,
    output logic                    tx_sck,
    output logic                    tx_ws,
    output logic                    tx_sd,

    // receive side
    input  logic                    rx_sck,
    input  logic                    rx_ws,
    input  logic                    rx_sd,
    output logic                    rx_valid,
    output logic [sample_width-1:0] rx_left,
    output logic [sample_width-1:0] rx_right
);

    i2s_bus_if      tx_bus ();
    stereo_sample_t tx_frame;  // packed load data
    stereo_sample_t rx_frame;  // received frame

    assign tx_frame.left  = tx_left;
    assign tx_frame.right = tx_right;

    ////////////////////
    // transmitter
    ////////////////////

    i2s_sck_gen i2s_sck_gen_i (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (tx_bus.clock_src)
    );

    i2s_serializer i2s_serializer_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .load      (tx_load),
        .frame_in  (tx_frame),
        .frame_req (tx_frame_req),
        .bus       (tx_bus.shifter)
    );

    assign tx_sck = tx_bus.sck;  // out to the pins
    assign tx_ws  = tx_bus.ws;
    assign tx_sd  = tx_bus.sd;

    ////////////////////
    // receiver
    ////////////////////

    i2s_deserializer i2s_deserializer_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .sck       (rx_sck),
        .ws        (rx_ws),
        .sd        (rx_sd),
        .valid     (rx_valid),
        .frame_out (rx_frame)
    );

    assign rx_left  = rx_frame.left;
    assign rx_right = rx_frame.right;

endmodule

`default_nettype wire

//--- testbench/i2s_link_checker.sv
`timescale 1ns/1ns
`default_nettype none

module i2s_link_checker
    import i2s_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    tx_load,
    input  logic [sample_width-1:0] tx_left,
    input  logic [sample_width-1:0] tx_right,
    input  logic                    tx_frame_req,
    input  logic                    tx_sck,
    input  logic                    tx_ws,
    input  logic                    tx_sd,
    input  logic                    rx_valid,
    input  logic [sample_width-1:0] rx_left,
    input  logic [sample_width-1:0] rx_right,
    output int                      data_errors,
    output int                      bus_errors,
    output int                      frames_checked
);

    localparam int frame_bits    = 2 * sample_width;
    localparam int pos_width     = $clog2(frame_bits);
    localparam int frame_cycles  = 2 * half_sck_cycles * frame_bits;  // 2112 clk
    localparam int latency_limit = frame_cycles + 70;

    stereo_sample_t hold_model = '0;  // mirrors the holding register
    stereo_sample_t cur_frame = '0;   // frame now on the wire
    stereo_sample_t exp_q[$];         // frames the receiver still owes
    int             req_time_q[$];    // cycle of each queued frame_req
    int             cycle;
    int             last_edge = -1;
    int             bit_pos;          // frame bit now on tx_sd
    int             reqs_seen;
    bit             sck_prev;
    bit             sck_toggled;

    ////////////////////
    // reference model
    ////////////////////

    // holding register one clk later, a load replaces it
    function automatic stereo_sample_t held_after(input stereo_sample_t held, input logic load,
                                                  input logic [sample_width-1:0] left,
                                                  input logic [sample_width-1:0] right);
        stereo_sample_t result;
        result = held;
        if (load)
        begin
            result.left  = left;
            result.right = right;
        end
        return result;
    endfunction

    // ws one bit early: left lsb and right 15..1 high
    function automatic logic ws_for_bit(input int pos);
        return (pos == sample_width - 1) || (pos >= sample_width && pos < frame_bits - 1);
    endfunction

    task automatic flag_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual, input bit is_data);
        $display("error at time %0t: %s expected %0h, got %0h", $time, name, expected, actual);
        if (is_data)
            data_errors++;
        else
            bus_errors++;
    endtask

    task automatic flag_event(input string what);
        $display("%s, at time %0t", what, $time);
        data_errors++;
    endtask

    ////////////////////
    // compare, once per clk
    ////////////////////

    always @(posedge clk)
    begin
        bit             rise_now;
        bit             fall_now;
        bit             exp_req;
        logic           exp_ws;
        logic           exp_sd;
        stereo_sample_t expected;

        rise_now = rst_n && tx_sck && !sck_prev;
        fall_now = rst_n && !tx_sck && sck_prev;

        // everything quiet through reset and up to the first sck toggle
        if ((!rst_n || !sck_toggled) && {tx_ws, tx_sd, tx_frame_req, rx_valid} !== 4'b0)
            flag_value("{tx_ws,tx_sd,tx_frame_req,rx_valid}", 32'(0),
                       32'({tx_ws, tx_sd, tx_frame_req, rx_valid}), 1'b0);
        if (!rst_n && tx_sck !== 1'b0)
            flag_value("tx_sck", 32'(0), 32'(tx_sck), 1'b0);

        if (rst_n)
        begin
            cycle++;
            if (rise_now || fall_now)
            begin
                if (last_edge >= 0 && cycle - last_edge != half_sck_cycles)
                    flag_value("tx_sck half period", 32'(half_sck_cycles),
                               32'(cycle - last_edge), 1'b0);
                last_edge   = cycle;
                sck_toggled = 1'b1;
            end

            // new frame on the first fall, then after every right lsb
            exp_req = fall_now && (reqs_seen == 0 || bit_pos == frame_bits - 1);
            if (tx_frame_req !== exp_req)
                flag_value("tx_frame_req", 32'(exp_req), 32'(tx_frame_req), 1'b0);
            if (exp_req)
            begin
                cur_frame = hold_model;
                bit_pos   = 0;
            end
            else if (fall_now)
                bit_pos++;
            if (tx_frame_req)
            begin
                if (reqs_seen > 0)  // receiver only arms on the first frame
                begin
                    exp_q.push_back(hold_model);
                    req_time_q.push_back(cycle);
                end
                reqs_seen++;
            end
            hold_model = held_after(hold_model, tx_load, tx_left, tx_right);

            // bus pins sampled mid bit
            if (rise_now)
            begin
                exp_ws = ws_for_bit(bit_pos);
                exp_sd = cur_frame[pos_width'(frame_bits - 1 - bit_pos)];  // msb first
                if (tx_ws !== exp_ws)
                    flag_value("tx_ws", 32'(exp_ws), 32'(tx_ws), 1'b0);
                if (tx_sd !== exp_sd)
                    flag_value("tx_sd", 32'(exp_sd), 32'(tx_sd), 1'b0);
            end

            if (rx_valid)
            begin
                if (exp_q.size() == 0)
                    flag_event("rx_valid pulsed with no frame outstanding");
                else
                begin
                    expected = exp_q.pop_front();
                    req_time_q.delete(0);
                    if (rx_left !== expected.left)
                        flag_value("rx_left", 32'(expected.left), 32'(rx_left), 1'b1);
                    if (rx_right !== expected.right)
                        flag_value("rx_right", 32'(expected.right), 32'(rx_right), 1'b1);
                    frames_checked++;
                end
            end

            // oldest frame overdue, drop it so later frames still line up
            if (req_time_q.size() > 0 && cycle - req_time_q[0] > latency_limit)
            begin
                flag_event("a frame was not received within one frame period plus 70 cycles");
                exp_q.delete(0);
                req_time_q.delete(0);
            end
        end

        sck_prev = (tx_sck === 1'b1);
    end

endmodule

`default_nettype wire

//--- testbench/tb_i2s_link.sv
`timescale 1ns/1ns
`default_nettype none

module tb_i2s_link
    import i2s_pkg::*;
();

    localparam int frame_cycles   = 4 * half_sck_cycles * sample_width;  // clk per frame
    localparam int frames_to_send = 24;

    logic                    clk = 1'b0;
    logic                    rst_n;
    logic                    tx_load;
    logic [sample_width-1:0] tx_left;
    logic [sample_width-1:0] tx_right;
    logic                    tx_frame_req;
    logic                    tx_sck;
    logic                    tx_ws;
    logic                    tx_sd;
    logic                    rx_sck;
    logic                    rx_ws;
    logic                    rx_sd;
    logic                    rx_valid;
    logic [sample_width-1:0] rx_left;
    logic [sample_width-1:0] rx_right;

    int          data_errors;     // from the checker
    int          bus_errors;
    int          frames_checked;
    int          timeouts;
    logic [31:0] rng_state = 32'he67e_92a0;

    always #4 clk = ~clk;  // 8 ns

    // loopback, transmit pins straight into the receiver
    assign rx_sck = tx_sck;
    assign rx_ws  = tx_ws;
    assign rx_sd  = tx_sd;

    i2s_link_top i2s_link_top_i (.*);

    i2s_link_checker i2s_link_checker_i (.*);

    ////////////////////
    // helpers
    ////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic wait_frame_req(output bit seen);
        int waited;
        seen   = 1'b0;
        waited = 0;
        while (!seen && waited < 2 * frame_cycles)
        begin
            @(posedge clk);
            waited++;
            seen = (tx_frame_req === 1'b1);
        end
        if (!seen)
        begin
            $display("timed out after %0d cycles waiting for tx_frame_req", waited);
            timeouts++;
        end
    endtask

    task automatic load_random_pair();
        rng_state = xorshift32(rng_state);
        @(negedge clk);
        tx_left  = rng_state[31:16];
        tx_right = rng_state[15:0];
        tx_load  = 1'b1;  // one clk strobe
        @(negedge clk);
        tx_load  = 1'b0;
    endtask

    task automatic wait_received(input int count, output bit done);
        int waited;
        done   = 1'b0;
        waited = 0;
        while (!done && waited < 3 * frame_cycles)
        begin
            @(negedge clk);  // checker counters settled by now
            waited++;
            done = (frames_checked >= count);
        end
        if (!done)
        begin
            $display("timed out waiting for %0d received frames, got %0d", count, frames_checked);
            timeouts++;
        end
    endtask

    task automatic finish_run();
        @(negedge clk);
        $display("frames compared %0d, data errors %0d, bus errors %0d, timeouts %0d",
                 frames_checked, data_errors, bus_errors, timeouts);
        if (data_errors == 0 && bus_errors == 0 && timeouts == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    endtask

    ////////////////////
    // stimulus
    ////////////////////

    initial
    begin
        bit ok;
        int sent;
        int gap;

        ok       = 1'b1;
        sent     = 0;
        rst_n    = 1'b0;
        tx_load  = 1'b0;
        tx_left  = '0;
        tx_right = '0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        while (ok && sent < frames_to_send)
        begin
            wait_frame_req(ok);
            if (ok)
            begin
                sent++;
                rng_state = xorshift32(rng_state);
                gap = 2 + int'(rng_state[2:0]);  // a few clk after the request
                repeat (gap) @(negedge clk);
                if (sent % 5 != 3)  // skipped slot, frame repeats
                    load_random_pair();
                if (sent % 7 == 4)  // second load in the same frame wins
                begin
                    repeat (3 * gap) @(negedge clk);
                    load_random_pair();
                end
            end
        end

        // last load goes out in the frame after the final request
        if (ok)
            wait_received(sent, ok);
        finish_run();
    end

endmodule

`default_nettype wire

//--- i2s_link_top.f
rtl/i2s_pkg.sv
rtl/i2s_bus_if.sv
rtl/i2s_sck_gen.sv
rtl/i2s_serializer.sv
rtl/i2s_deserializer.sv
rtl/i2s_link_top.sv
testbench/i2s_link_checker.sv
testbench/tb_i2s_link.sv

//--- run.sh
#!/bin/sh
# build and run the I2S link testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_i2s_link -f i2s_link_top.f -o sim_i2s_link

out=$(./obj_dir/sim_i2s_link)
echo "$out"

if echo "$out" | grep -q "Simulation completed successfully"; then
    exit 0
fi
exit 1
